// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= line_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_FLAGS ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then exit 1; fi
	@grep -q "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== line_control.sv ====
`timescale 1ns/1ps

module line_control (
  input  logic       i_clk,
  input  logic       i_reset,
  line_cmd_if.lane   cmd,
  pixel_if.lane      pix,
  // to datapath
  output logic       o_ld_initial,
  output logic       o_update_error,
  output logic       o_update_x,
  output logic       o_update_y,
  output logic [1:0] o_mux_cmp0,
  output logic       o_mux_alu0,
  output logic       o_mux_alu1,
  // from datapath
  input  logic       i_keep_drawing,
  input  logic       i_pix_fire,
  output logic       o_line_done
);
  import line_pkg::*;

  engine_state_t state;
  // second cycle of S_INIT
  logic          init_load;

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      state     <= S_IDLE;
      init_load <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          init_load <= 1'b0;
          if (cmd.valid) begin
            state <= S_INIT;
          end
        end
        S_INIT: begin
          init_load <= 1'b1;
          if (init_load) begin
            state <= S_LOOP_CHECK;
          end
        end
        S_LOOP_CHECK: state <= i_keep_drawing ? S_DRAW : S_DONE;
        S_DRAW: begin
          // step only once the pixel has left
          if (i_pix_fire) begin
            state <= S_LOOP_CHECK;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_comb begin
    o_ld_initial   = 1'b0;
    o_update_error = 1'b0;
    o_update_x     = 1'b0;
    o_update_y     = 1'b0;
    o_mux_cmp0     = 2'd1;
    o_mux_alu0     = 1'b1;
    o_mux_alu1     = 1'b1;
    case (state)
      S_INIT: begin
        o_mux_cmp0 = 2'd0;
        if (init_load) begin
          o_ld_initial = 1'b1;
        end else begin
          // absolute differences
          o_mux_alu0 = 1'b0;
          o_mux_alu1 = 1'b0;
        end
      end
      S_DRAW: begin
        o_mux_cmp0     = 2'd2;
        o_update_error = i_pix_fire;
        o_update_x     = i_pix_fire;
        o_update_y     = i_pix_fire;
      end
      default: o_mux_cmp0 = 2'd1;
    endcase
  end

  assign pix.valid   = (state == S_DRAW);
  assign cmd.busy    = (state != S_IDLE) && (state != S_DONE);
  assign o_line_done = (state == S_DONE);

endmodule

// ==== line_datapath.sv ====
`timescale 1ns/1ps

module line_datapath (
  input  logic       i_clk,
  input  logic       i_reset,
  line_cmd_if.lane   cmd,
  // from control
  input  logic       i_ld_initial,
  input  logic       i_update_error,
  input  logic       i_update_x,
  input  logic       i_update_y,
  input  logic [1:0] i_mux_cmp0,
  input  logic       i_mux_alu0,
  input  logic       i_mux_alu1,
  // to control
  output logic       o_keep_drawing,
  output logic       o_pix_fire,
  pixel_if.lane      pix
);
  import line_pkg::*;

  // command captured at issue
  coord_x_t   cx0;
  coord_y_t   cy0;
  coord_x_t   cx1;
  coord_y_t   cy1;
  color_t     col;
  // absolute differences from the first init cycle
  coord_x_t   adx;
  coord_x_t   ady;
  // x is the major axis after the steep swap, so y needs the full width
  logic       steep;
  coord_x_t   dx;
  coord_x_t   dy;
  coord_x_t   error;
  coord_x_t   x;
  coord_x_t   y;
  coord_x_t   xstop;
  logic [1:0] xstep;
  logic [1:0] ystep;
  logic       x_up;
  logic       y_up;
  logic       maj_up;
  logic       min_up;
  logic       cmp0;
  logic [9:0] alu0;
  logic [9:0] alu1;

  assign x_up   = cx1 > cx0;
  assign y_up   = cy1 > cy0;
  // cmp0 holds the steep decision during the load cycle
  assign maj_up = cmp0 ? y_up : x_up;
  assign min_up = cmp0 ? x_up : y_up;

  always_comb begin
    // alu 0 gives |y1 - y0| in init and error - dy in draw
    if (i_mux_alu0) begin
      alu0 = {1'b0, error} - {1'b0, dy};
    end else begin
      alu0 = y_up ? {2'b00, cy1 - cy0} : {2'b00, cy0 - cy1};
    end
    // alu 1 gives |x1 - x0| in init and error - dy + dx in draw
    if (i_mux_alu1) begin
      alu1 = alu0 + {1'b0, dx};
    end else begin
      alu1 = x_up ? {1'b0, cx1 - cx0} : {1'b0, cx0 - cx1};
    end
    case (i_mux_cmp0)
      2'd0:    cmp0 = ady > adx;
      2'd1:    cmp0 = x != xstop;
      2'd2:    cmp0 = alu0[9];
      default: cmp0 = 1'b0;
    endcase
  end

  assign o_keep_drawing = cmp0;
  assign o_pix_fire     = pix.valid && pix.ready;

  // undo the steep swap on the way out
  assign pix.x     = steep ? y : x;
  assign pix.y     = steep ? x[7:0] : y[7:0];
  assign pix.color = col;

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      cx0 <= '0;
      cy0 <= '0;
      cx1 <= '0;
      cy1 <= '0;
      col <= '0;
      adx <= '0;
      ady <= '0;
    end else begin
      if (cmd.valid) begin
        cx0 <= cmd.x0;
        cy0 <= cmd.y0;
        cx1 <= cmd.x1;
        cy1 <= cmd.y1;
        col <= cmd.color;
      end
      if (!i_mux_alu0 && !i_mux_alu1) begin
        adx <= alu1[8:0];
        ady <= alu0[8:0];
      end
    end
  end

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      steep <= 1'b0;
      dx    <= '0;
      dy    <= '0;
      error <= '0;
      x     <= '0;
      y     <= '0;
      xstop <= '0;
      xstep <= '0;
      ystep <= '0;
    end else if (i_ld_initial) begin
      steep <= cmp0;
      dx    <= cmp0 ? ady : adx;
      dy    <= cmp0 ? adx : ady;
      error <= (cmp0 ? ady : adx) >> 1;
      x     <= cmp0 ? {1'b0, cy0} : cx0;
      y     <= cmp0 ? cx0 : {1'b0, cy0};
      xstep <= maj_up ? 2'b01 : 2'b11;
      ystep <= min_up ? 2'b01 : 2'b11;
      // one past the end point, wraps to 511 when stepping down to 0
      xstop <= (cmp0 ? {1'b0, cy1} : cx1) + (maj_up ? 9'd1 : 9'h1ff);
    end else begin
      if (i_update_error) begin
        error <= cmp0 ? alu1[8:0] : alu0[8:0];
      end
      // minor axis moves when error went negative
      if (i_update_y && cmp0) begin
        y <= y + {{7{ystep[1]}}, ystep};
      end
      if (i_update_x) begin
        x <= x + {{7{xstep[1]}}, xstep};
      end
    end
  end

endmodule

// ==== line_dispatch.sv ====
`timescale 1ns/1ps

module line_dispatch #(
  parameter int N_LANES = 4
) (
  input  logic               i_clk,
  input  logic               i_reset,
  input  logic               i_cmd_valid,
  input  line_pkg::coord_x_t i_cmd_x0,
  input  line_pkg::coord_y_t i_cmd_y0,
  input  line_pkg::coord_x_t i_cmd_x1,
  input  line_pkg::coord_y_t i_cmd_y1,
  input  line_pkg::color_t   i_cmd_color,
  output logic               o_cmd_accept,
  line_cmd_if.dispatcher     cmd [N_LANES]
);
  import line_pkg::*;

  logic [N_LANES-1:0] busy;
  logic [N_LANES-1:0] issue_q;
  logic [N_LANES-1:0] free;
  logic [N_LANES-1:0] pick;
  coord_x_t           x0_q;
  coord_y_t           y0_q;
  coord_x_t           x1_q;
  coord_y_t           y1_q;
  color_t             color_q;

  // a lane issued to last cycle has not raised busy yet
  assign free = ~busy & ~issue_q;
  // lowest free lane
  assign pick = free & (~free + 1'b1);
  assign o_cmd_accept = i_cmd_valid && (|free);

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      issue_q <= '0;
    end else begin
      issue_q <= o_cmd_accept ? pick : '0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_cmd_accept) begin
      x0_q    <= i_cmd_x0;
      y0_q    <= i_cmd_y0;
      x1_q    <= i_cmd_x1;
      y1_q    <= i_cmd_y1;
      color_q <= i_cmd_color;
    end
  end

  // coordinates go to every lane, only the picked lane sees valid
  for (genvar i = 0; i < N_LANES; i++) begin : g_lane
    assign busy[i]      = cmd[i].busy;
    assign cmd[i].valid = issue_q[i];
    assign cmd[i].x0    = x0_q;
    assign cmd[i].y0    = y0_q;
    assign cmd[i].x1    = x1_q;
    assign cmd[i].y1    = y1_q;
    assign cmd[i].color = color_q;
  end

endmodule

// ==== line_if.sv ====
`timescale 1ns/1ps

// command slot between the dispatcher and one lane
interface line_cmd_if;
  import line_pkg::*;

  logic     valid;
  coord_x_t x0;
  coord_y_t y0;
  coord_x_t x1;
  coord_y_t y1;
  color_t   color;
  logic     busy;

  modport dispatcher (
    output valid, x0, y0, x1, y1, color,
    input  busy
  );

  modport lane (
    input  valid, x0, y0, x1, y1, color,
    output busy
  );

endinterface

// ready/valid pixel stream from one lane
interface pixel_if;
  import line_pkg::*;

  logic     valid;
  coord_x_t x;
  coord_y_t y;
  color_t   color;
  logic     ready;

  modport lane (
    output valid, x, y, color,
    input  ready
  );

  modport merger (
    input  valid, x, y, color,
    output ready
  );

endinterface

// ==== line_pkg.sv ====
package line_pkg;

  // 320x240 screen coordinates
  typedef logic [8:0] coord_x_t;
  typedef logic [7:0] coord_y_t;
  typedef logic [2:0] color_t;

  // sized for the default four lanes
  typedef logic [1:0] lane_id_t;

  // host register map
  localparam logic [3:0] REG_P0     = 4'h0;
  localparam logic [3:0] REG_P1     = 4'h4;
  localparam logic [3:0] REG_LAUNCH = 4'h8;
  localparam logic [3:0] REG_STATUS = 4'hC;

  typedef enum logic [2:0] {
    S_IDLE,
    S_INIT,
    S_LOOP_CHECK,
    S_DRAW,
    S_DONE
  } engine_state_t;

endpackage

// ==== line_properties.sv ====
`timescale 1ns/1ps

module line_properties (
  input logic               i_clk,
  input logic               i_reset,
  input logic               o_pix_valid,
  input logic               i_pix_ready,
  input line_pkg::coord_x_t o_pix_x,
  input line_pkg::coord_y_t o_pix_y,
  input line_pkg::color_t   o_pix_color,
  input line_pkg::lane_id_t o_pix_lane,
  input logic               i_awvalid,
  input logic               o_awready,
  input logic               o_wready,
  input logic               o_bvalid,
  input logic               i_bready,
  input logic               o_arready,
  input logic               o_rvalid
);

  int   fail_count = 0;
  // a write was accepted and its response has not yet been taken
  logic wr_open;

  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      wr_open <= 1'b0;
    end else if (i_awvalid && o_awready) begin
      wr_open <= 1'b1;
    end else if (o_bvalid && i_bready) begin
      wr_open <= 1'b0;
    end
  end

  // output data held while stalled
  a_stall_stable: assert property (@(posedge i_clk) disable iff (i_reset)
    (o_pix_valid && !i_pix_ready) |=> (o_pix_valid && $stable(o_pix_x) &&
      $stable(o_pix_y) && $stable(o_pix_color) && $stable(o_pix_lane)))
  else begin
    fail_count++;
    $error("output pixel changed under stall");
  end

  a_no_x: assert property (@(posedge i_clk) disable iff (i_reset)
    !$isunknown({o_pix_valid, o_awready, o_wready, o_bvalid, o_arready, o_rvalid}))
  else begin
    fail_count++;
    $error("handshake output is unknown");
  end

  // one response per write, never a response without a write
  a_resp_owed: assert property (@(posedge i_clk) disable iff (i_reset)
    o_bvalid |-> wr_open)
  else begin
    fail_count++;
    $error("write response without an open write");
  end

  a_one_open: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_awvalid && o_awready) |-> !wr_open)
  else begin
    fail_count++;
    $error("second write accepted before the first response");
  end

endmodule

bind line_top line_properties line_properties_inst (
  .i_clk       (i_clk),
  .i_reset     (i_reset),
  .o_pix_valid (o_pix_valid),
  .i_pix_ready (i_pix_ready),
  .o_pix_x     (o_pix_x),
  .o_pix_y     (o_pix_y),
  .o_pix_color (o_pix_color),
  .o_pix_lane  (o_pix_lane),
  .i_awvalid   (i_awvalid),
  .o_awready   (o_awready),
  .o_wready    (o_wready),
  .o_bvalid    (o_bvalid),
  .i_bready    (i_bready),
  .o_arready   (o_arready),
  .o_rvalid    (o_rvalid)
);

// ==== line_regs.sv ====
`timescale 1ns/1ps

module line_regs #(
  parameter int N_LANES = 4
) (
  input  logic                i_clk,
  input  logic                i_reset,
  // AXI4-Lite slave
  input  logic [3:0]          i_awaddr,
  input  logic                i_awvalid,
  output logic                o_awready,
  input  logic [31:0]         i_wdata,
  input  logic                i_wvalid,
  output logic                o_wready,
  output logic [1:0]          o_bresp,
  output logic                o_bvalid,
  input  logic                i_bready,
  input  logic [3:0]          i_araddr,
  input  logic                i_arvalid,
  output logic                o_arready,
  output logic [31:0]         o_rdata,
  output logic [1:0]          o_rresp,
  output logic                o_rvalid,
  input  logic                i_rready,
  // command towards the dispatcher
  output logic                o_cmd_valid,
  output line_pkg::coord_x_t  o_cmd_x0,
  output line_pkg::coord_y_t  o_cmd_y0,
  output line_pkg::coord_x_t  o_cmd_x1,
  output line_pkg::coord_y_t  o_cmd_y1,
  output line_pkg::color_t    o_cmd_color,
  input  logic                i_cmd_accept,
  input  logic [N_LANES-1:0]  i_lane_busy,
  input  logic                i_line_done
);
  import line_pkg::*;

  logic        wr_fire;
  logic        rd_fire;
  logic [15:0] line_count;
  logic [31:0] status_word;

  // address and data are taken in the same cycle
  assign wr_fire  = o_awready && i_awvalid && i_wvalid;
  assign rd_fire  = o_arready && i_arvalid;
  assign o_wready = o_awready;
  assign o_bresp  = 2'b00;
  assign o_rresp  = 2'b00;

  always_comb begin
    status_word = '0;
    status_word[N_LANES-1:0] = i_lane_busy;
    status_word[31:16] = line_count;
  end

  // write path
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      o_awready   <= 1'b0;
      o_bvalid    <= 1'b0;
      o_cmd_valid <= 1'b0;
      o_cmd_x0    <= '0;
      o_cmd_y0    <= '0;
      o_cmd_x1    <= '0;
      o_cmd_y1    <= '0;
      o_cmd_color <= '0;
    end else begin
      // one transaction in flight, a pending launch blocks the next one
      o_awready <= !o_awready && i_awvalid && i_wvalid && !o_bvalid && !o_cmd_valid;
      if (o_bvalid && i_bready) begin
        o_bvalid <= 1'b0;
      end
      // launch response waits for the dispatcher
      if (o_cmd_valid && i_cmd_accept) begin
        o_cmd_valid <= 1'b0;
        o_bvalid    <= 1'b1;
      end
      if (wr_fire) begin
        case (i_awaddr)
          REG_P0: begin
            o_cmd_x0 <= i_wdata[8:0];
            o_cmd_y0 <= i_wdata[23:16];
            o_bvalid <= 1'b1;
          end
          REG_P1: begin
            o_cmd_x1    <= i_wdata[8:0];
            o_cmd_y1    <= i_wdata[23:16];
            o_cmd_color <= i_wdata[26:24];
            o_bvalid    <= 1'b1;
          end
          REG_LAUNCH: o_cmd_valid <= 1'b1;
          default:    o_bvalid <= 1'b1;
        endcase
      end
    end
  end

  // completed lines
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      line_count <= '0;
    end else if (i_line_done) begin
      line_count <= line_count + 16'd1;
    end
  end

  // read path
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      o_arready <= 1'b0;
      o_rvalid  <= 1'b0;
      o_rdata   <= '0;
    end else begin
      o_arready <= !o_arready && i_arvalid && !o_rvalid;
      if (o_rvalid && i_rready) begin
        o_rvalid <= 1'b0;
      end
      if (rd_fire) begin
        o_rvalid <= 1'b1;
        case (i_araddr)
          REG_P0:     o_rdata <= {8'h00, o_cmd_y0, 7'h00, o_cmd_x0};
          REG_P1:     o_rdata <= {5'h00, o_cmd_color, o_cmd_y1, 7'h00, o_cmd_x1};
          REG_STATUS: o_rdata <= status_word;
          default:    o_rdata <= '0;
        endcase
      end
    end
  end

endmodule

// ==== line_tb.sv ====
`timescale 1ns/1ps

module line_tb;
  import line_pkg::*;

  localparam int N_LANES = 4;

  logic        i_clk;
  logic        i_reset;
  logic [3:0]  i_awaddr;
  logic        i_awvalid;
  logic        o_awready;
  logic [31:0] i_wdata;
  logic        i_wvalid;
  logic        o_wready;
  logic [1:0]  o_bresp;
  logic        o_bvalid;
  logic        i_bready;
  logic [3:0]  i_araddr;
  logic        i_arvalid;
  logic        o_arready;
  logic [31:0] o_rdata;
  logic [1:0]  o_rresp;
  logic        o_rvalid;
  logic        i_rready;
  logic        o_pix_valid;
  coord_x_t    o_pix_x;
  coord_y_t    o_pix_y;
  color_t      o_pix_color;
  lane_id_t    o_pix_lane;
  logic        i_pix_ready;

  // expected pixels per lane packed as {x, y, color}
  logic [19:0] exp_q [N_LANES][$];
  logic [19:0] line_q [$];
  logic [19:0] pend_q [$];
  logic        pend_valid = 1'b0;
  int          errors = 0;
  int          checks = 0;
  int          launched = 0;
  int          budget_cycles = 4000;
  int          cycles = 0;
  logic [31:0] rng = 32'd3635;
  logic [31:0] ready_rng = 32'd3635;
  logic        stall_en = 1'b0;
  time         free_time = 0;
  int          lines [15][5] = '{
    '{50, 50, 50, 50, 1}, '{10, 100, 200, 100, 2}, '{200, 110, 10, 110, 3},
    '{30, 10, 30, 200, 4}, '{40, 200, 40, 10, 5}, '{20, 20, 150, 70, 6},
    '{150, 80, 20, 120, 7}, '{20, 200, 180, 150, 1}, '{300, 230, 100, 180, 2},
    '{60, 10, 90, 200, 3}, '{90, 200, 60, 10, 4}, '{100, 10, 70, 180, 5},
    '{70, 180, 100, 10, 6}, '{0, 0, 100, 100, 7}, '{319, 239, 0, 0, 0}
  };

  line_top #(
    .N_LANES (N_LANES)
  ) line_top_inst (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic int iabs(input int v);
    return (v < 0) ? -v : v;
  endfunction

  // Bresenham reference with x as the major axis after the steep swap
  function automatic void build_line(input int x0, input int y0, input int x1, input int y1,
                                     input int c);
    int steep;
    int ax0;
    int ay0;
    int ax1;
    int ay1;
    int dx;
    int dy;
    int err;
    int x;
    int y;
    int xs;
    int ys;
    line_q.delete();
    steep = (iabs(y1 - y0) > iabs(x1 - x0)) ? 1 : 0;
    ax0 = steep ? y0 : x0;
    ay0 = steep ? x0 : y0;
    ax1 = steep ? y1 : x1;
    ay1 = steep ? x1 : y1;
    dx = iabs(ax1 - ax0);
    dy = iabs(ay1 - ay0);
    err = dx / 2;
    xs = (ax1 > ax0) ? 1 : -1;
    ys = (ay1 > ay0) ? 1 : -1;
    x = ax0;
    y = ay0;
    forever begin
      if (steep != 0) line_q.push_back({9'(y), 8'(x), 3'(c)});
      else line_q.push_back({9'(x), 8'(y), 3'(c)});
      if (x == ax1) break;
      err = err - dy;
      if (err < 0) begin
        y = y + ys;
        err = err + dx;
      end
      x = x + xs;
    end
  endfunction

  function automatic logic all_drained();
    logic empty;
    empty = !pend_valid;
    for (int i = 0; i < N_LANES; i++) begin
      if (exp_q[i].size() != 0) empty = 1'b0;
    end
    return empty;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    assert (expected === actual) else begin
      $display("mismatch %s expected %h actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // callers start on a rising edge
  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
    i_awaddr  <= addr;
    i_wdata   <= data;
    i_awvalid <= 1'b1;
    i_wvalid  <= 1'b1;
    do @(posedge i_clk); while (!(o_awready && o_wready));
    i_awvalid <= 1'b0;
    i_wvalid  <= 1'b0;
    do @(posedge i_clk); while (!o_bvalid);
    check_value("o_bresp", 32'h0, 32'(o_bresp));
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
    i_araddr  <= addr;
    i_arvalid <= 1'b1;
    do @(posedge i_clk); while (!o_arready);
    i_arvalid <= 1'b0;
    do @(posedge i_clk); while (!o_rvalid);
    check_value("o_rresp", 32'h0, 32'(o_rresp));
    data = o_rdata;
  endtask

  // lane predicted as the lowest idle one or pending when all are busy
  task automatic launch_line(input int x0, input int y0, input int x1, input int y1,
                             input int c, output int lane);
    logic [31:0] st;
    build_line(x0, y0, x1, y1, c);
    budget_cycles += line_q.size() * 12 + 300;
    axi_write(REG_P0, {8'h00, 8'(y0), 7'h00, 9'(x0)});
    axi_write(REG_P1, {5'h00, 3'(c), 8'(y1), 7'h00, 9'(x1)});
    axi_read(REG_STATUS, st);
    lane = -1;
    for (int i = N_LANES - 1; i >= 0; i--) begin
      if (!st[i]) lane = i;
    end
    if (lane < 0) begin
      pend_q = line_q;
      pend_valid = 1'b1;
    end else begin
      exp_q[lane] = line_q;
    end
    launched++;
    axi_write(REG_LAUNCH, 32'h0);
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    st = 32'hffff_ffff;
    while (!all_drained()) @(posedge i_clk);
    while (st[N_LANES-1:0] != '0) axi_read(REG_STATUS, st);
  endtask

  task automatic random_line(output int lane);
    int x0;
    int y0;
    int x1;
    int y1;
    rng = xorshift(rng);
    x0 = int'(rng % 100);
    y0 = int'((rng >> 8) % 240);
    rng = xorshift(rng);
    x1 = 200 + int'(rng % 120);
    y1 = int'((rng >> 8) % 240);
    launch_line(x0, y0, x1, y1, int'(rng[26:24]), lane);
  endtask

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;
  end

  // output checker
  always @(posedge i_clk) begin
    logic [19:0] e;
    if (!i_reset && o_pix_valid && i_pix_ready) begin
      if (exp_q[o_pix_lane].size() == 0) begin
        $display("pixel on lane %0d with no line expected", o_pix_lane);
        errors++;
      end else begin
        e = exp_q[o_pix_lane].pop_front();
        check_value("o_pix_x", 32'(e[19:11]), 32'(o_pix_x));
        check_value("o_pix_y", 32'(e[10:3]), 32'(o_pix_y));
        check_value("o_pix_color", 32'(e[2:0]), 32'(o_pix_color));
        if (exp_q[o_pix_lane].size() == 0) begin
          if (free_time == 0) free_time = $time;
          if (pend_valid) begin
            exp_q[o_pix_lane] = pend_q;
            pend_valid = 1'b0;
          end
        end
      end
    end
  end

  // output back-pressure
  initial begin
    forever begin
      @(posedge i_clk);
      ready_rng = xorshift(ready_rng);
      i_pix_ready <= stall_en ? ready_rng[4] : 1'b1;
    end
  end

  // watchdog grows with the pixels launched so far
  initial begin
    forever begin
      @(posedge i_clk);
      cycles++;
      if (cycles > budget_cycles) begin
        $display("timeout after %0d cycles with pixels still outstanding", cycles);
        $display("=== FAIL ===");
        $finish;
      end
    end
  end

  initial begin
    logic [31:0] st;
    int          lane;
    time         resp_time;
    i_reset     <= 1'b1;
    i_awaddr    <= '0;
    i_awvalid   <= 1'b0;
    i_wdata     <= '0;
    i_wvalid    <= 1'b0;
    i_bready    <= 1'b1;
    i_araddr    <= '0;
    i_arvalid   <= 1'b0;
    i_rready    <= 1'b1;
    i_pix_ready <= 1'b1;
    repeat (3) @(posedge i_clk);
    i_reset <= 1'b0;
    @(posedge i_clk);

    check_value("o_pix_valid", 32'h0, 32'(o_pix_valid));
    check_value("o_awready", 32'h0, 32'(o_awready));
    check_value("o_wready", 32'h0, 32'(o_wready));
    check_value("o_bvalid", 32'h0, 32'(o_bvalid));
    check_value("o_arready", 32'h0, 32'(o_arready));
    check_value("o_rvalid", 32'h0, 32'(o_rvalid));
    axi_read(REG_STATUS, st);
    check_value("status", 32'h0, st);
    $display("test 1 reset state finished, errors %0d", errors);

    for (int i = 0; i < 15; i++) begin
      launch_line(lines[i][0], lines[i][1], lines[i][2], lines[i][3], lines[i][4], lane);
      wait_idle();
    end
    $display("test 2 line directions finished, errors %0d", errors);

    for (int i = 0; i < N_LANES; i++) begin
      random_line(lane);
      check_value("lane", 32'(i), 32'(lane));
    end
    wait_idle();
    $display("test 3 parallel lanes finished, errors %0d", errors);

    stall_en = 1'b1;
    for (int i = 0; i < N_LANES; i++) begin
      random_line(lane);
      check_value("lane", 32'(i), 32'(lane));
    end
    wait_idle();
    stall_en = 1'b0;
    $display("test 4 output back-pressure finished, errors %0d", errors);

    free_time = 0;
    // lane 3 gets the shortest line and frees first
    launch_line(0, 0, 300, 10, 1, lane);
    launch_line(0, 20, 250, 30, 2, lane);
    launch_line(0, 40, 200, 50, 3, lane);
    launch_line(0, 60, 60, 70, 4, lane);
    launch_line(10, 100, 150, 120, 5, lane);
    resp_time = $time;
    checks++;
    assert (free_time != 0 && free_time < resp_time) else begin
      $display("launch response arrived before any lane finished its line");
      errors++;
    end
    wait_idle();
    axi_read(REG_STATUS, st);
    check_value("line_count", 32'(launched), 32'(st[31:16]));
    $display("test 5 launch back-pressure and status finished, errors %0d", errors);

    $display("tests 5, checks %0d, errors %0d, assertion failures %0d", checks, errors,
             line_top_inst.line_properties_inst.fail_count);
    if (errors == 0 && line_top_inst.line_properties_inst.fail_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== line_top.sv ====
`timescale 1ns/1ps

module line_top #(
  parameter int N_LANES = 4
) (
  input  logic               i_clk,
  input  logic               i_reset,
  // AXI4-Lite host port
  input  logic [3:0]         i_awaddr,
  input  logic               i_awvalid,
  output logic               o_awready,
  input  logic [31:0]        i_wdata,
  input  logic               i_wvalid,
  output logic               o_wready,
  output logic [1:0]         o_bresp,
  output logic               o_bvalid,
  input  logic               i_bready,
  input  logic [3:0]         i_araddr,
  input  logic               i_arvalid,
  output logic               o_arready,
  output logic [31:0]        o_rdata,
  output logic [1:0]         o_rresp,
  output logic               o_rvalid,
  input  logic               i_rready,
  // pixel stream to the frame buffer side
  output logic               o_pix_valid,
  output line_pkg::coord_x_t o_pix_x,
  output line_pkg::coord_y_t o_pix_y,
  output line_pkg::color_t   o_pix_color,
  output line_pkg::lane_id_t o_pix_lane,
  input  logic               i_pix_ready
);
  import line_pkg::*;

  logic               cmd_valid;
  logic               cmd_accept;
  coord_x_t           cmd_x0;
  coord_y_t           cmd_y0;
  coord_x_t           cmd_x1;
  coord_y_t           cmd_y1;
  color_t             cmd_color;
  logic [N_LANES-1:0] lane_busy;
  logic [N_LANES-1:0] lane_done;
  logic               line_done;

  line_cmd_if cmd_if [N_LANES] ();
  pixel_if    pix_if [N_LANES] ();

  // the lane tag must be wide enough
  if (N_LANES < 1 || N_LANES > (1 << $bits(lane_id_t))) begin : g_lane_check
    $fatal(1, "N_LANES does not fit lane_id_t");
  end

  // the merger serialises pixels, so two lanes never finish in the same cycle
  assign line_done = |lane_done;

  line_regs #(
    .N_LANES (N_LANES)
  ) line_regs_inst (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_awaddr     (i_awaddr),
    .i_awvalid    (i_awvalid),
    .o_awready    (o_awready),
    .i_wdata      (i_wdata),
    .i_wvalid     (i_wvalid),
    .o_wready     (o_wready),
    .o_bresp      (o_bresp),
    .o_bvalid     (o_bvalid),
    .i_bready     (i_bready),
    .i_araddr     (i_araddr),
    .i_arvalid    (i_arvalid),
    .o_arready    (o_arready),
    .o_rdata      (o_rdata),
    .o_rresp      (o_rresp),
    .o_rvalid     (o_rvalid),
    .i_rready     (i_rready),
    .o_cmd_valid  (cmd_valid),
    .o_cmd_x0     (cmd_x0),
    .o_cmd_y0     (cmd_y0),
    .o_cmd_x1     (cmd_x1),
    .o_cmd_y1     (cmd_y1),
    .o_cmd_color  (cmd_color),
    .i_cmd_accept (cmd_accept),
    .i_lane_busy  (lane_busy),
    .i_line_done  (line_done)
  );

  line_dispatch #(
    .N_LANES (N_LANES)
  ) line_dispatch_inst (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_cmd_valid  (cmd_valid),
    .i_cmd_x0     (cmd_x0),
    .i_cmd_y0     (cmd_y0),
    .i_cmd_x1     (cmd_x1),
    .i_cmd_y1     (cmd_y1),
    .i_cmd_color  (cmd_color),
    .o_cmd_accept (cmd_accept),
    .cmd          (cmd_if)
  );

  for (genvar i = 0; i < N_LANES; i++) begin : g_lane
    logic       ld_initial;
    logic       update_error;
    logic       update_x;
    logic       update_y;
    logic [1:0] mux_cmp0;
    logic       mux_alu0;
    logic       mux_alu1;
    logic       keep_drawing;
    logic       pix_fire;

    assign lane_busy[i] = cmd_if[i].busy;

    line_control line_control_inst (
      .i_clk          (i_clk),
      .i_reset        (i_reset),
      .cmd            (cmd_if[i]),
      .pix            (pix_if[i]),
      .o_ld_initial   (ld_initial),
      .o_update_error (update_error),
      .o_update_x     (update_x),
      .o_update_y     (update_y),
      .o_mux_cmp0     (mux_cmp0),
      .o_mux_alu0     (mux_alu0),
      .o_mux_alu1     (mux_alu1),
      .i_keep_drawing (keep_drawing),
      .i_pix_fire     (pix_fire),
      .o_line_done    (lane_done[i])
    );

    line_datapath line_datapath_inst (
      .i_clk          (i_clk),
      .i_reset        (i_reset),
      .cmd            (cmd_if[i]),
      .i_ld_initial   (ld_initial),
      .i_update_error (update_error),
      .i_update_x     (update_x),
      .i_update_y     (update_y),
      .i_mux_cmp0     (mux_cmp0),
      .i_mux_alu0     (mux_alu0),
      .i_mux_alu1     (mux_alu1),
      .o_keep_drawing (keep_drawing),
      .o_pix_fire     (pix_fire),
      .pix            (pix_if[i])
    );
  end

  pixel_merge #(
    .N_LANES (N_LANES)
  ) pixel_merge_inst (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .pix         (pix_if),
    .o_pix_valid (o_pix_valid),
    .o_pix_x     (o_pix_x),
    .o_pix_y     (o_pix_y),
    .o_pix_color (o_pix_color),
    .o_pix_lane  (o_pix_lane),
    .i_pix_ready (i_pix_ready)
  );

endmodule

// ==== pixel_merge.sv ====
`timescale 1ns/1ps

module pixel_merge #(
  parameter int N_LANES = 4
) (
  input  logic               i_clk,
  input  logic               i_reset,
  pixel_if.merger            pix [N_LANES],
  output logic               o_pix_valid,
  output line_pkg::coord_x_t o_pix_x,
  output line_pkg::coord_y_t o_pix_y,
  output line_pkg::color_t   o_pix_color,
  output line_pkg::lane_id_t o_pix_lane,
  input  logic               i_pix_ready
);
  import line_pkg::*;

  logic [N_LANES-1:0] req;
  coord_x_t           px [N_LANES];
  coord_y_t           py [N_LANES];
  color_t             pc [N_LANES];
  lane_id_t           grant;
  lane_id_t           grant_next;
  int                 idx;

  for (genvar i = 0; i < N_LANES; i++) begin : g_lane
    assign req[i]       = pix[i].valid;
    assign px[i]        = pix[i].x;
    assign py[i]        = pix[i].y;
    assign pc[i]        = pix[i].color;
    assign pix[i].ready = i_pix_ready && (grant == lane_id_t'(i));
  end

  assign o_pix_valid = req[grant];
  assign o_pix_x     = px[grant];
  assign o_pix_y     = py[grant];
  assign o_pix_color = pc[grant];
  assign o_pix_lane  = grant;

  // first requester after the current grant, current lane last
  always_comb begin
    grant_next = grant;
    idx = 0;
    for (int k = N_LANES; k >= 1; k--) begin
      idx = (int'(grant) + k) % N_LANES;
      if (req[idx]) begin
        grant_next = lane_id_t'(idx);
      end
    end
  end

  // grant is held while the output is stalled
  always_ff @(posedge i_clk or posedge i_reset) begin
    if (i_reset) begin
      grant <= '0;
    end else if (!o_pix_valid || i_pix_ready) begin
      grant <= grant_next;
    end
  end

endmodule

// ==== vlog.f ====
line_pkg.sv
line_if.sv
line_regs.sv
line_dispatch.sv
line_control.sv
line_datapath.sv
pixel_merge.sv
line_top.sv
line_properties.sv
line_tb.sv
